/* char_engine.sv */
`default_nettype none

module char_engine (
	input wire clock,
	input wire reset,
	output char_engine_pkg::reg_index_t reg_sel,
	input wire char_engine_pkg::data_word_t reg_data,
	input wire [15:0] cycle_count,
	output char_engine_pkg::fb_addr_t write_addr,
	output char_engine_pkg::glyph_row_t write_data,
	output logic write_valid,
	input wire write_ready
);
	import char_engine_pkg::*;

	field_kind_t field_kind;
	text_row_t field_row;
	text_col_t field_col;
	data_word_t field_value;
	logic field_active;
	logic field_done;
	char_index_t field_length;
	char_index_t char_index;
	glyph_line_t glyph_line;
	char_code_t char_code;
	glyph_row_t pixel_byte;
	logic pixel_valid;
	logic pixel_ready;

	field_sequencer u_field_sequencer (
		.clock(clock),
		.reset(reset),
		.field_done(field_done),
		.reg_data(reg_data),
		.cycle_count(cycle_count),
		.reg_sel(reg_sel),
		.field_kind(field_kind),
		.field_row(field_row),
		.field_col(field_col),
		.field_value(field_value),
		.field_active(field_active)
	);

	glyph_counter u_glyph_counter (
		.clock(clock),
		.reset(reset),
		.field_active(field_active),
		.field_length(field_length),
		.pixel_ready(pixel_ready),
		.char_index(char_index),
		.glyph_line(glyph_line),
		.pixel_valid(pixel_valid),
		.field_done(field_done)
	);

	field_text u_field_text (
		.field_kind(field_kind),
		.field_value(field_value),
		.char_index(char_index),
		.char_code(char_code),
		.field_length(field_length)
	);

	glyph_rom u_glyph_rom (
		.char_code(char_code),
		.glyph_line(glyph_line),
		.pixel_byte(pixel_byte)
	);

	pixel_writer u_pixel_writer (
		.clock(clock),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_byte(pixel_byte),
		.field_row(field_row),
		.field_col(field_col),
		.char_index(char_index),
		.glyph_line(glyph_line),
		.pixel_ready(pixel_ready),
		.write_ready(write_ready),
		.write_addr(write_addr),
		.write_data(write_data),
		.write_valid(write_valid)
	);

endmodule

`default_nettype wire

/* char_engine_pkg.sv */
`default_nettype none

package char_engine_pkg;

	typedef logic [5:0] char_code_t; // Font index
	typedef logic [7:0] glyph_row_t; // Bit 7 is the leftmost pixel
	typedef logic [2:0] glyph_line_t;
	typedef logic [15:0] fb_addr_t;
	typedef logic [5:0] text_row_t; // 0 to 47
	typedef logic [6:0] text_col_t; // 0 to 79
	typedef logic [3:0] char_index_t;
	typedef logic [4:0] reg_index_t;
	typedef logic [31:0] data_word_t;

	typedef enum logic [2:0] {
		FIELD_REG_LABEL,
		FIELD_CYCLE_LABEL,
		FIELD_REG_INDEX,
		FIELD_REG_VALUE,
		FIELD_CYCLES
	} field_kind_t;

	// 640 pixels per line at one bit each
	localparam fb_addr_t LINE_BYTES = 16'd80;
	localparam fb_addr_t TEXT_ROW_BYTES = 16'd800; // Ten pixel lines per text row
	localparam int GLYPH_ROWS = 8;

	localparam int NUM_REGS = 32;

	localparam char_code_t CHAR_COLON = 6'h27;
	localparam char_code_t CHAR_SPACE = 6'h24;

	// Screen layout
	localparam text_col_t REG_PANE_COL = 7'd50;
	localparam text_col_t REG_VALUE_COL = 7'd52;
	localparam text_row_t CYCLES_ROW = 6'd35;
	localparam text_col_t CYCLES_VALUE_COL = 7'd8;

	localparam char_code_t LABEL_REGISTERS [9] = '{
		6'h1B, 6'h0E, 6'h10, 6'h12, 6'h1C, // R E G I S
		6'h1D, 6'h0E, 6'h1B, 6'h1C // T E R S
	};

	localparam char_code_t LABEL_CYCLES [7] = '{
		6'h0C, 6'h22, 6'h0C, 6'h15, // C Y C L
		6'h0E, 6'h1C, 6'h27 // E S :
	};

endpackage

`default_nettype wire

/* field_sequencer.sv */
`default_nettype none

module field_sequencer (
	input wire clock,
	input wire reset,
	input wire field_done,
	input wire char_engine_pkg::data_word_t reg_data,
	input wire [15:0] cycle_count,
	output char_engine_pkg::reg_index_t reg_sel,
	output char_engine_pkg::field_kind_t field_kind,
	output char_engine_pkg::text_row_t field_row,
	output char_engine_pkg::text_col_t field_col,
	output char_engine_pkg::data_word_t field_value,
	output logic field_active
);
	import char_engine_pkg::*;

	typedef enum logic [1:0] {
		SETUP,
		SAMPLE,
		EMIT
	} seq_state_t;

	localparam reg_index_t LAST_REG = reg_index_t'(NUM_REGS - 1);

	seq_state_t state;
	text_row_t pane_row;

	assign pane_row = text_row_t'(reg_sel) + 6'd1; // Row 0 holds the pane label

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= SETUP;
			field_kind <= FIELD_REG_LABEL; // Labels are drawn once after reset
			reg_sel <= '0;
			field_active <= 1'b0;
		end else begin
			case (state)
				SETUP: begin
					state <= SAMPLE;
				end
				SAMPLE: begin
					field_active <= 1'b1;
					state <= EMIT;
				end
				default: begin
					if (field_done) begin
						field_active <= 1'b0;
						state <= SETUP;
						case (field_kind)
							FIELD_REG_LABEL: field_kind <= FIELD_CYCLE_LABEL;
							FIELD_CYCLE_LABEL: field_kind <= FIELD_REG_INDEX;
							FIELD_REG_INDEX: field_kind <= FIELD_REG_VALUE;
							FIELD_REG_VALUE: begin
								reg_sel <= reg_sel + 5'd1; // Wraps to 0 after the last one
								if (reg_sel == LAST_REG)
									field_kind <= FIELD_CYCLES;
								else
									field_kind <= FIELD_REG_INDEX;
							end
							default: field_kind <= FIELD_REG_INDEX; // Back to the top of the pane
						endcase
					end
				end
			endcase
		end
	end

	// Position of the field on screen
	always_ff @(posedge clock) begin
		if (state == SETUP) begin
			case (field_kind)
				FIELD_REG_LABEL: begin
					field_row <= '0;
					field_col <= REG_PANE_COL;
				end
				FIELD_CYCLE_LABEL: begin
					field_row <= CYCLES_ROW;
					field_col <= '0;
				end
				FIELD_REG_INDEX: begin
					field_row <= pane_row;
					field_col <= REG_PANE_COL;
				end
				FIELD_REG_VALUE: begin
					field_row <= pane_row;
					field_col <= REG_VALUE_COL;
				end
				default: begin
					field_row <= CYCLES_ROW;
					field_col <= CYCLES_VALUE_COL;
				end
			endcase
		end
	end

	// Value is frozen here for the whole draw
	always_ff @(posedge clock) begin
		if (state == SAMPLE) begin
			case (field_kind)
				FIELD_REG_INDEX: field_value <= data_word_t'(reg_sel);
				FIELD_REG_VALUE: field_value <= reg_data;
				FIELD_CYCLES: field_value <= data_word_t'(cycle_count);
				default: field_value <= '0; // Labels carry no value
			endcase
		end
	end

	// The counter may only finish a field that is being drawn
	assert property (@(posedge clock) disable iff (reset) field_done |-> state == EMIT);

endmodule

`default_nettype wire

/* field_text.sv */
`default_nettype none

module field_text (
	input wire char_engine_pkg::field_kind_t field_kind,
	input wire char_engine_pkg::data_word_t field_value,
	input wire char_engine_pkg::char_index_t char_index,
	output char_engine_pkg::char_code_t char_code,
	output char_engine_pkg::char_index_t field_length
);
	import char_engine_pkg::*;

	char_index_t nibble_sel;
	char_code_t hex_code;

	always_comb begin
		case (field_kind)
			FIELD_REG_LABEL: field_length = 4'd9;
			FIELD_CYCLE_LABEL: field_length = 4'd7;
			FIELD_REG_INDEX: field_length = 4'd2;
			FIELD_REG_VALUE: field_length = 4'd9; // Colon and eight digits
			default: field_length = 4'd4;
		endcase
	end

	// Rightmost character shows the lowest nibble
	assign nibble_sel = field_length - 4'd1 - char_index;
	assign hex_code = {2'b00, field_value[{nibble_sel[2:0], 2'b00} +: 4]};

	always_comb begin
		char_code = CHAR_SPACE; // Past the end of the field
		if (char_index < field_length) begin
			case (field_kind)
				FIELD_REG_LABEL: char_code = LABEL_REGISTERS[char_index];
				FIELD_CYCLE_LABEL: char_code = LABEL_CYCLES[char_index[2:0]];
				FIELD_REG_VALUE: begin
					if (char_index == '0)
						char_code = CHAR_COLON;
					else
						char_code = hex_code;
				end
				default: char_code = hex_code; // Index and cycles are pure hex
			endcase
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
char_engine_pkg.sv
glyph_rom.sv
field_sequencer.sv
glyph_counter.sv
field_text.sv
pixel_writer.sv
char_engine.sv
tb_char_engine.sv

/* glyph_counter.sv */
`default_nettype none

module glyph_counter (
	input wire clock,
	input wire reset,
	input wire field_active,
	input wire char_engine_pkg::char_index_t field_length,
	input wire pixel_ready,
	output char_engine_pkg::char_index_t char_index,
	output char_engine_pkg::glyph_line_t glyph_line,
	output logic pixel_valid,
	output logic field_done
);
	import char_engine_pkg::*;

	logic accept;
	logic last_line;
	logic last_char;

	assign pixel_valid = field_active; // One pixel on offer per cycle
	assign accept = pixel_valid && pixel_ready;
	assign last_line = glyph_line == glyph_line_t'(GLYPH_ROWS - 1);
	assign last_char = char_index == field_length - 4'd1;
	assign field_done = accept && last_line && last_char;

	// Glyph line is the inner loop
	always_ff @(posedge clock) begin
		if (reset) begin
			char_index <= '0;
			glyph_line <= '0;
		end else if (accept) begin
			if (last_line) begin
				glyph_line <= '0;
				if (last_char)
					char_index <= '0; // Ready for the next field
				else
					char_index <= char_index + 4'd1;
			end else begin
				glyph_line <= glyph_line + 3'd1;
			end
		end
	end

	// Field length comes from the text decoder
	assert property (@(posedge clock) disable iff (reset)
		field_active |-> char_index < field_length);

endmodule

`default_nettype wire

/* glyph_rom.sv */
`default_nettype none

module glyph_rom (
	input wire char_engine_pkg::char_code_t char_code,
	input wire char_engine_pkg::glyph_line_t glyph_line,
	output char_engine_pkg::glyph_row_t pixel_byte
);
	import char_engine_pkg::*;

	logic [63:0] glyph; // Top line in the most significant byte

	always_comb begin
		case (char_code)
			6'h00: glyph = 64'h3C424242_4242423C; // 0
			6'h01: glyph = 64'h18387818_1818187E;
			6'h02: glyph = 64'h3C66660C_1830607E;
			6'h03: glyph = 64'h7C06067C_0606067C;
			6'h04: glyph = 64'h0E162646_467E0606;
			6'h05: glyph = 64'h7E606078_0C060C78;
			6'h06: glyph = 64'h3C40407C_4242423C;
			6'h07: glyph = 64'h7E060606_0C183060;
			6'h08: glyph = 64'h3C42423C_4242423C;
			6'h09: glyph = 64'h3C464646_3E060606;
			6'h0A: glyph = 64'h3C424242_7E424242; // A
			6'h0B: glyph = 64'h7C42467C_4642427C;
			6'h0C: glyph = 64'h3E606060_6060603E;
			6'h0D: glyph = 64'h7C626262_6262627C;
			6'h0E: glyph = 64'h3E60607E_6060603E;
			6'h0F: glyph = 64'h7E60607E_60606060;
			6'h10: glyph = 64'h3C60606E_6666663C; // G
			6'h11: glyph = 64'h6666667E_66666666;
			6'h12: glyph = 64'h7E181818_1818187E;
			6'h13: glyph = 64'h7E060606_0606663C;
			6'h14: glyph = 64'h66666C70_706C6666;
			6'h15: glyph = 64'h60606060_6060607E;
			6'h16: glyph = 64'h42665A5A_42424242;
			6'h17: glyph = 64'h42426252_4A464242;
			6'h18: glyph = 64'h3C424242_4242423C;
			6'h19: glyph = 64'h7C424242_7C606060;
			6'h1A: glyph = 64'h3C424242_4242443A;
			6'h1B: glyph = 64'h3C424242_7C584C46;
			6'h1C: glyph = 64'h3C40403C_0202023C;
			6'h1D: glyph = 64'h7E181818_18181818;
			6'h1E: glyph = 64'h42424242_4242423C;
			6'h1F: glyph = 64'h42424242_42422418;
			6'h20: glyph = 64'h42424242_5A5A6642;
			6'h21: glyph = 64'h42422418_18244242;
			6'h22: glyph = 64'h42424224_18181818;
			6'h23: glyph = 64'h7E06060C_3060607E; // Z
			CHAR_SPACE: glyph = 64'h00000000_00000000;
			6'h25: glyph = 64'hFFFFFFFF_FFFFFFFF; // Solid block
			6'h26: glyph = 64'h0000007E_00000000; // Dash
			CHAR_COLON: glyph = 64'h00181800_00181800;
			6'h28: glyph = 64'h00000000_0000C0C0; // Full stop
			default: glyph = 64'h00000000_00000000; // Unused codes stay blank
		endcase
	end

	// Line 0 sits in bits 63:56
	assign pixel_byte = glyph[{~glyph_line, 3'b000} +: 8];

endmodule

`default_nettype wire

/* pixel_writer.sv */
`default_nettype none

module pixel_writer (
	input wire clock,
	input wire reset,
	input wire pixel_valid,
	input wire char_engine_pkg::glyph_row_t pixel_byte,
	input wire char_engine_pkg::text_row_t field_row,
	input wire char_engine_pkg::text_col_t field_col,
	input wire char_engine_pkg::char_index_t char_index,
	input wire char_engine_pkg::glyph_line_t glyph_line,
	output logic pixel_ready,
	input wire write_ready,
	output char_engine_pkg::fb_addr_t write_addr,
	output char_engine_pkg::glyph_row_t write_data,
	output logic write_valid
);
	import char_engine_pkg::*;

	fb_addr_t line_offset;
	fb_addr_t pixel_addr;

	// Line 0 of each text row is the blank spacer
	assign line_offset = fb_addr_t'(glyph_line) + 16'd1;
	assign pixel_addr = TEXT_ROW_BYTES * fb_addr_t'(field_row)
		+ LINE_BYTES * line_offset
		+ fb_addr_t'(field_col)
		+ fb_addr_t'(char_index);

	// Free when empty or draining this cycle
	assign pixel_ready = !write_valid || write_ready;

	always_ff @(posedge clock) begin
		if (reset)
			write_valid <= 1'b0;
		else if (pixel_ready)
			write_valid <= pixel_valid;
	end

	always_ff @(posedge clock) begin
		if (pixel_valid && pixel_ready) begin
			write_addr <= pixel_addr;
			write_data <= pixel_byte;
		end
	end

	// A stalled write keeps its contents until the frame buffer takes it
	assert property (@(posedge clock) disable iff (reset)
		write_valid && !write_ready |=>
			write_valid && $stable(write_addr) && $stable(write_data));

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f filelist.f --top-module tb_char_engine \
	-o sim_char_engine &&
./obj_dir/sim_char_engine | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tb_char_engine.sv */
`default_nettype none

module tb_char_engine;
	import char_engine_pkg::*;

	// Labels plus two passes of the register pane and the cycles field
	localparam int TOTAL_TRANSFERS = 9 * 8 + 7 * 8 + 2 * (32 * (2 + 9) * 8 + 4 * 8);

	logic clock = 1'b0;
	logic reset;
	logic [15:0] cycle_count;
	logic write_ready = 1'b1;
	reg_index_t reg_sel;
	data_word_t reg_data;
	fb_addr_t write_addr;
	glyph_row_t write_data;
	logic write_valid;

	logic [31:0] reg_table [32];
	logic [31:0] lfsr_state = 32'heec887b9;
	logic stall_mode = 1'b0;
	logic [23:0] exp_queue [$]; // {address, data}
	logic [23:0] got_queue [$];
	logic held_valid = 1'b0;
	logic [23:0] held_word;
	int error_count = 0;
	int tests_passed = 0;
	int tests_failed = 0;

	char_engine uut (
		.clock(clock),
		.reset(reset),
		.reg_sel(reg_sel),
		.reg_data(reg_data),
		.cycle_count(cycle_count),
		.write_addr(write_addr),
		.write_data(write_data),
		.write_valid(write_valid),
		.write_ready(write_ready)
	);

	always #5 clock = ~clock;

	assign reg_data = reg_table[reg_sel]; // CPU register file read

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int n = 0; n < count; n++) begin
			value = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	// Font subset with the top line in the high byte
	function automatic logic [63:0] glyph_of(input byte ch);
		case (ch)
			"0": return 64'h3C424242_4242423C;
			"1": return 64'h18387818_1818187E;
			"2": return 64'h3C66660C_1830607E;
			"3": return 64'h7C06067C_0606067C;
			"4": return 64'h0E162646_467E0606;
			"5": return 64'h7E606078_0C060C78;
			"6": return 64'h3C40407C_4242423C;
			"7": return 64'h7E060606_0C183060;
			"8": return 64'h3C42423C_4242423C;
			"9": return 64'h3C464646_3E060606;
			"A": return 64'h3C424242_7E424242;
			"B": return 64'h7C42467C_4642427C;
			"C": return 64'h3E606060_6060603E;
			"D": return 64'h7C626262_6262627C;
			"E": return 64'h3E60607E_6060603E;
			"F": return 64'h7E60607E_60606060;
			"G": return 64'h3C60606E_6666663C;
			"I": return 64'h7E181818_1818187E;
			"L": return 64'h60606060_6060607E;
			"R": return 64'h3C424242_7C584C46;
			"S": return 64'h3C40403C_0202023C;
			"T": return 64'h7E181818_18181818;
			"Y": return 64'h42424224_18181818;
			":": return 64'h00181800_00181800;
			default: return 64'h0;
		endcase
	endfunction

	function automatic string hex_string(input logic [31:0] value, input int digits);
		string text;
		logic [3:0] nibble;
		text = "";
		for (int n = digits - 1; n >= 0; n--) begin
			nibble = 4'(value >> (4 * n)); // Most significant first
			if (nibble < 4'd10)
				text = $sformatf("%s%c", text, {4'h3, nibble});
			else
				text = $sformatf("%s%c", text, 8'h37 + {4'h0, nibble});
		end
		return text;
	endfunction

	// Text row is 10 lines with the glyph from line 1
	task automatic push_field(input int row, input int col, input string text);
		logic [63:0] glyph;
		for (int i = 0; i < text.len(); i++) begin
			glyph = glyph_of(text[i]);
			for (int line = 0; line < 8; line++) begin
				exp_queue.push_back({16'(800 * row + 80 * (line + 1) + col + i),
					8'(glyph >> (56 - 8 * line))});
			end
		end
	endtask

	task automatic push_register_fields();
		for (int i = 0; i < 32; i++) begin
			push_field(i + 1, 50, hex_string(32'(i), 2));
			push_field(i + 1, 52, {":", hex_string(reg_table[i], 8)});
		end
	endtask

	task automatic compare_stream();
		logic [23:0] want_word;
		logic [23:0] seen_word;
		int k;
		k = 0;
		while (exp_queue.size() > 0) begin
			while (got_queue.size() == 0)
				@(posedge clock);
			want_word = exp_queue.pop_front();
			seen_word = got_queue.pop_front();
			if (seen_word[23:8] !== want_word[23:8]) begin
				error_count = error_count + 1;
				$display("mismatch write_addr at transfer %0d: expected %h, got %h",
					k, want_word[23:8], seen_word[23:8]);
			end
			if (seen_word[7:0] !== want_word[7:0]) begin
				error_count = error_count + 1;
				$display("mismatch write_data at transfer %0d: expected %h, got %h",
					k, want_word[7:0], seen_word[7:0]);
			end
			k++;
		end
	endtask

	task automatic report_test(input string name, input int start_errors);
		if (error_count == start_errors) begin
			tests_passed++;
			$display("%s: passed", name);
		end else begin
			tests_failed++;
			$display("%s: failed with %0d errors", name, error_count - start_errors);
		end
	endtask

	task automatic expect_idle(input string when);
		@(negedge clock);
		if (write_valid !== 1'b0) begin
			error_count = error_count + 1;
			$display("mismatch write_valid %s: expected 0, got %h", when, write_valid);
		end
	endtask

	task automatic quiet_during_reset();
		int start;
		start = error_count;
		expect_idle("during reset");
		expect_idle("during reset");
		@(posedge clock);
		reset <= 1'b0; // Third reset cycle ends here
		expect_idle("during reset");
		expect_idle("in the first cycle after reset");
		if (reg_sel !== '0) begin
			error_count = error_count + 1;
			$display("mismatch reg_sel after reset: expected 00, got %h", reg_sel);
		end
		report_test("quiet_during_reset", start);
	endtask

	task automatic label_stream();
		int start;
		start = error_count;
		push_field(0, 50, "REGISTERS");
		push_field(35, 0, "CYCLES:");
		compare_stream();
		report_test("label_stream", start);
	endtask

	task automatic register_pane();
		int start;
		start = error_count;
		push_register_fields();
		compare_stream();
		report_test("register_pane", start);
	endtask

	task automatic cycles_field();
		int start;
		start = error_count;
		push_field(35, 8, hex_string({16'h0, cycle_count}, 4));
		compare_stream();
		report_test("cycles_field", start);
	endtask

	// Next pass restarts at register 0 with no labels
	task automatic stalled_second_pass();
		int start;
		start = error_count;
		stall_mode <= 1'b1;
		push_register_fields();
		push_field(35, 8, hex_string({16'h0, cycle_count}, 4));
		compare_stream();
		stall_mode <= 1'b0;
		report_test("stalled_second_pass", start);
	endtask

	always @(posedge clock) begin
		if (stall_mode)
			write_ready <= take_bits(1) != 32'd0;
		else
			write_ready <= 1'b1;
	end

	// Transfer monitor and handshake rules
	always @(posedge clock) begin
		if (!reset) begin
			if (held_valid && !write_valid) begin
				error_count = error_count + 1;
				$display("write_valid dropped without a transfer");
			end else if (held_valid) begin
				if (write_addr !== held_word[23:8]) begin
					error_count = error_count + 1;
					$display("mismatch write_addr while stalled: expected %h, got %h",
						held_word[23:8], write_addr);
				end
				if (write_data !== held_word[7:0]) begin
					error_count = error_count + 1;
					$display("mismatch write_data while stalled: expected %h, got %h",
						held_word[7:0], write_data);
				end
			end
			if (write_valid && write_ready)
				got_queue.push_back({write_addr, write_data});
			held_valid = write_valid && !write_ready;
			held_word = {write_addr, write_data};
		end
	end

	initial begin
		repeat (TOTAL_TRANSFERS * 4 + 2000) @(posedge clock);
		$display("timeout: the expected transfers did not all arrive");
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		cycle_count = 16'hB7E4;
		for (int i = 0; i < 32; i++) begin
			reg_table[i] = take_bits(32);
		end
		quiet_during_reset();
		label_stream();
		register_pane();
		cycles_field();
		stalled_second_pass();
		$display("tests passed %0d, failed %0d, errors %0d",
			tests_passed, tests_failed, error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
